// File: logic/bus_pkg.sv
package bus_pkg;

    // Shared RAM geometry, 2 KB of bytes
    localparam int addr_w = 11;                 // Word address bits
    localparam int data_w = 8;                  // Byte wide

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;

    // One master's access toward the RAM
    // Main bus, MCU and sound CPU all use the same shape
    // Plain levels, no handshake: the slot decides when it lands
    typedef struct packed {
        logic  cs;                              // Select level
        logic  rnw;                             // High for read
        addr_t addr;                            // Byte address
        data_t wdata;                           // Write data, don't care on reads
    } mem_req_t;

endpackage

// File: logic/slice_pkg.sv
package slice_pkg;

    // Who drives RAM port 1 in the current window
    typedef enum logic {
        OWN_SND = 1'b0,                         // Sound CPU window
        OWN_MCU = 1'b1                          // MCU window
    } owner_e;

    // Enable generator state, one value per clock
    // Only one of the two enables can fire in a given cycle
    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,                         // Neither enable
        PH_SND  = 2'd1,                         // snd_cen cycle
        PH_MCU  = 2'd2                          // mcu_cen cycle
    } phase_e;

endpackage

// File: logic/dual_ram.sv
module dual_ram #(
    parameter int aw = 11,
    parameter int dw = 8
) (
    input  logic          clk,
    // Port 0
    input  logic          we0,
    input  logic [aw-1:0] addr0,
    input  logic [dw-1:0] data0,
    output logic [dw-1:0] q0,
    // Port 1
    input  logic          we1,
    input  logic [aw-1:0] addr1,
    input  logic [dw-1:0] data1,
    output logic [dw-1:0] q1
);

    logic [dw-1:0] mem [0:(1<<aw)-1];           // Storage array, no reset

    // Port 0, read before write
    always @(posedge clk) begin
        q0 <= mem[addr0];                       // Old word during own write
        if (we0) begin
            mem[addr0] <= data0;
        end
    end

    // Port 1, same behaviour
    always @(posedge clk) begin
        q1 <= mem[addr1];
        if (we1) begin
            mem[addr1] <= data1;
        end
    end

    // Result of a same-address write collision is undefined in silicon
    // The masters must keep their addresses apart
    a_no_collide : assert property (
        @(posedge clk) !(we0 && we1 && (addr0 == addr1))
    ) else $error("dual_ram: both ports write address %0h", addr0);

endmodule

// File: logic/cen_gen.sv
module cen_gen #(
    parameter int cpu_period = 8                // Clocks per slow CPU cycle
) (
    input  logic clk,
    input  logic arst_n,
    output logic snd_cen,
    output logic mcu_cen
);

    localparam int cw   = $clog2(cpu_period);
    localparam int half = cpu_period / 2;

    localparam logic [cw-1:0] snd_at = cw'(half - 1);       // Count before snd phase
    localparam logic [cw-1:0] last   = cw'(cpu_period - 1); // Wrap point, before mcu phase

    logic [cw-1:0]     cnt;
    slice_pkg::phase_e phase, phase_nxt;

    // Free running modulo counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= (cnt == last) ? '0 : cnt + 1'b1;
        end
    end

    // Decode the count into the next phase
    always_comb begin
        case (cnt)
            snd_at:  phase_nxt = slice_pkg::PH_SND;
            last:    phase_nxt = slice_pkg::PH_MCU;          // Half a period later
            default: phase_nxt = slice_pkg::PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= slice_pkg::PH_IDLE;                     // Quiet until first snd phase
        end else begin
            phase <= phase_nxt;
        end
    end

    assign snd_cen = (phase == slice_pkg::PH_SND);
    assign mcu_cen = (phase == slice_pkg::PH_MCU);

    // The slices need room for at least a few cycles each
    initial begin
        a_period : assert ((cpu_period % 2 == 0) && (cpu_period >= 6))
            else $fatal(1, "cen_gen: cpu_period %0d must be even and >= 6", cpu_period);
    end

    // Registered phase lines up with the counter, half a period apart
    a_apart : assert property (
        @(posedge clk) disable iff (!arst_n)
        (snd_cen |-> (cnt == cw'(half))) and (mcu_cen |-> (cnt == '0))
    ) else $error("cen_gen: enable out of step with counter");

endmodule

// File: logic/tri_ram.sv
module tri_ram (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               snd_cen,
    input  logic                               mcu_cen,
    input  bus_pkg::mem_req_t                  mcu_req,
    input  bus_pkg::mem_req_t                  snd_req,
    input  logic [bus_pkg::data_w-1:0]         q1,      // RAM port 1 read data
    // RAM port 1 controls
    output logic                               we1,
    output logic [bus_pkg::addr_w-1:0]         addr1,
    output logic [bus_pkg::data_w-1:0]         data1,
    // Access being served, for the doorbell
    output bus_pkg::mem_req_t                  x_req,
    output slice_pkg::owner_e                  owner,
    output logic [bus_pkg::data_w-1:0]         mcu_rdata,
    output logic [bus_pkg::data_w-1:0]         snd_rdata
);

    bus_pkg::mem_req_t sel;                     // Owner's raw request
    logic              fresh;                   // First cycle of a window

    // Window switching
    // Sound CPU has the port until its cen, then the MCU until its own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner <= slice_pkg::OWN_SND;
        end else begin
            if (snd_cen) owner <= slice_pkg::OWN_MCU;
            if (mcu_cen) owner <= slice_pkg::OWN_SND;
        end
    end

    // q1 in the first cycle still carries the old owner's address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fresh <= 1'b1;                      // Nothing valid right after reset
        end else begin
            fresh <= snd_cen | mcu_cen;         // Owner flips on this edge
        end
    end

    // Port 1 mux
    always_comb begin
        sel     = (owner == slice_pkg::OWN_MCU) ? mcu_req : snd_req;
        we1     = sel.cs & ~sel.rnw;
        x_req   = sel;
        x_req.wdata = we1 ? sel.wdata : '0;     // Quiet data bus when not writing
        addr1   = x_req.addr;
        data1   = x_req.wdata;
    end

    // Read data steering, the idle side keeps its last byte
    always_ff @(posedge clk) begin
        if (!fresh) begin
            if (owner == slice_pkg::OWN_MCU) begin
                mcu_rdata <= q1;
            end else begin
                snd_rdata <= q1;
            end
        end
    end

    // Slices are tied to the CPU clocks, each cen must close
    // the window of its own CPU
    a_owner_flip : assert property (
        @(posedge clk) disable iff (!arst_n)
        (snd_cen |-> (owner == slice_pkg::OWN_SND)) and
        (mcu_cen |-> (owner == slice_pkg::OWN_MCU))
    ) else $error("tri_ram: cen outside its own window");

endmodule

// File: logic/doorbell.sv
module doorbell (
    input  logic              clk,
    input  logic              arst_n,
    input  bus_pkg::mem_req_t bus_req,          // Main bus, port 0
    input  bus_pkg::mem_req_t x_req,            // Port 1 access in service
    input  slice_pkg::owner_e owner,            // Who made the port 1 access
    output logic              mcu_irq,          // Toward the MCU
    output logic              bus_irq           // Toward main and sub CPUs
);

    logic bus_hit, x_hit;                       // Word 0 selected
    logic bus_wr0, bus_rd0;
    logic x_wr0, mcu_rd0;

    assign bus_hit = bus_req.cs && (bus_req.addr == '0);
    assign x_hit   = x_req.cs && (x_req.addr == '0);

    // Main bus side
    assign bus_wr0 = bus_hit & ~bus_req.rnw;    // Rings the MCU
    assign bus_rd0 = bus_hit &  bus_req.rnw;    // Acknowledges its own bell

    // Port 1 side, either CPU may ring
    assign x_wr0   = x_hit & ~x_req.rnw;
    // Only the MCU acknowledges, a sound read leaves the bell
    assign mcu_rd0 = x_hit & x_req.rnw & (owner == slice_pkg::OWN_MCU);

    // MCU bell
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcu_irq <= 1'b0;
        end else if (bus_wr0) begin
            mcu_irq <= 1'b1;                    // Set beats clear
        end else if (mcu_rd0) begin
            mcu_irq <= 1'b0;
        end
    end

    // Main bus bell
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_irq <= 1'b0;
        end else if (x_wr0) begin
            bus_irq <= 1'b1;
        end else if (bus_rd0) begin
            bus_irq <= 1'b0;
        end
    end

endmodule

// File: logic/shared_ram_top.sv
module shared_ram_top #(
    parameter int cpu_period = 8
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  bus_pkg::mem_req_t          bus_req,     // Main and sub CPUs
    input  bus_pkg::mem_req_t          mcu_req,
    input  bus_pkg::mem_req_t          snd_req,
    output logic [bus_pkg::data_w-1:0] bus_rdata,
    output logic [bus_pkg::data_w-1:0] mcu_rdata,
    output logic [bus_pkg::data_w-1:0] snd_rdata,
    output logic                       snd_cen,
    output logic                       mcu_cen,
    output logic                       mcu_irq,
    output logic                       bus_irq
);

    logic                       bus_we;
    logic                       we1;
    logic [bus_pkg::addr_w-1:0] addr1;
    logic [bus_pkg::data_w-1:0] data1, q1;
    bus_pkg::mem_req_t          x_req;
    slice_pkg::owner_e          owner;

    assign bus_we = bus_req.cs & ~bus_req.rnw;     // Port 0 write strobe

    cen_gen #(.cpu_period(cpu_period)) u_cen (
        .clk     (clk),
        .arst_n  (arst_n),
        .snd_cen (snd_cen),
        .mcu_cen (mcu_cen)
    );

    // Time sliced port 1
    tri_ram u_tri (
        .clk       (clk),
        .arst_n    (arst_n),
        .snd_cen   (snd_cen),
        .mcu_cen   (mcu_cen),
        .mcu_req   (mcu_req),
        .snd_req   (snd_req),
        .q1        (q1),
        .we1       (we1),
        .addr1     (addr1),
        .data1     (data1),
        .x_req     (x_req),
        .owner     (owner),
        .mcu_rdata (mcu_rdata),
        .snd_rdata (snd_rdata)
    );

    dual_ram #(
        .aw (bus_pkg::addr_w),
        .dw (bus_pkg::data_w)
    ) u_ram (
        .clk   (clk),
        .we0   (bus_we),                           // Main bus at full speed
        .addr0 (bus_req.addr),
        .data0 (bus_req.wdata),
        .q0    (bus_rdata),
        .we1   (we1),
        .addr1 (addr1),
        .data1 (data1),
        .q1    (q1)
    );

    doorbell u_bell (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus_req (bus_req),
        .x_req   (x_req),
        .owner   (owner),
        .mcu_irq (mcu_irq),
        .bus_irq (bus_irq)
    );

endmodule

// File: tb/tb_clock.sv
module tb_clock #(
    parameter int rst_cycles = 5                // Clocks held in reset
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: tb/shared_ram_tb.sv
module shared_ram_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cpu_period = 8;
    localparam int max_cycles = 4000;           // Roughly 1000 cycles of tests, with margin

    logic                       clk, arst_n;
    bus_pkg::mem_req_t          bus_req, mcu_req, snd_req;
    logic [bus_pkg::data_w-1:0] bus_rdata, mcu_rdata, snd_rdata;
    logic                       snd_cen, mcu_cen, mcu_irq, bus_irq;

    logic [bus_pkg::data_w-1:0] shadow [0:(1<<bus_pkg::addr_w)-1];  // Expected RAM words

    logic                       bus_chk, bus_chk_q;     // Main bus read in flight
    logic [bus_pkg::data_w-1:0] bus_exp, bus_exp_q;
    logic                       mcu_chk, snd_chk;       // Port 1 read windows
    logic [bus_pkg::data_w-1:0] mcu_exp, snd_exp;
    logic [bus_pkg::data_w-1:0] mcu_hold, snd_hold;     // Idle side's rdata
    logic                       mcu_irq_chk, bus_irq_chk;
    logic                       mcu_irq_exp, bus_irq_exp;
    logic                       ring_q;                 // Main bus wrote word 0 last edge
    logic                       seen_snd;
    int                         snd_gap;                // Cycles since last snd_cen
    int                         cycles = 0;

    tb_clock u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    shared_ram_top #(.cpu_period(cpu_period)) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus_req   (bus_req),
        .mcu_req   (mcu_req),
        .snd_req   (snd_req),
        .bus_rdata (bus_rdata),
        .mcu_rdata (mcu_rdata),
        .snd_rdata (snd_rdata),
        .snd_cen   (snd_cen),
        .mcu_cen   (mcu_cen),
        .mcu_irq   (mcu_irq),
        .bus_irq   (bus_irq)
    );

    task automatic report_fail(input string test, input int exp, input int act);
        $display("ERR %s expected %0h actual %0h", test, exp, act);
        $display("TEST FAIL");
        $fatal(1, "%s check failed", test);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    function automatic bus_pkg::mem_req_t make_req(input logic cs, input logic rnw,
                                                   input int addr, input int data);
        bus_pkg::mem_req_t r;
        r.cs    = cs;
        r.rnw   = rnw;
        r.addr  = bus_pkg::addr_t'(addr);
        r.wdata = bus_pkg::data_t'(data);
        return r;
    endfunction

    // Main bus, one access per call, level held until the next call
    task automatic bus_write(input int addr, input int data);
        @(negedge clk);
        bus_req      = make_req(1'b1, 1'b0, addr, data);
        bus_chk      = 1'b0;
        shadow[addr] = bus_pkg::data_t'(data);
    endtask

    task automatic bus_read(input int addr);
        @(negedge clk);
        bus_req = make_req(1'b1, 1'b1, addr, 0);
        bus_exp = shadow[addr];                 // Due one cycle later
        bus_chk = 1'b1;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        bus_req = make_req(1'b0, 1'b1, 0, 0);
        bus_chk = 1'b0;
    endtask

    task automatic wait_cen(input bit of_mcu);
        do begin
            @(negedge clk);
        end while (of_mcu ? !mcu_cen : !snd_cen);
    endtask

    // One request held through a whole port 1 window of one side
    task automatic slot_access(input bit to_mcu, input logic rnw, input int addr, input int data);
        bus_pkg::mem_req_t r;
        r = make_req(1'b1, rnw, addr, data);
        wait_cen(!to_mcu);                      // Window opens on the other side's cen
        if (to_mcu) begin
            mcu_req = r;
            mcu_exp = shadow[addr];
            mcu_chk = rnw;
        end else begin
            snd_req = r;
            snd_exp = shadow[addr];
            snd_chk = rnw;
        end
        if (!rnw) shadow[addr] = bus_pkg::data_t'(data);
        @(negedge clk);                         // Owner has flipped by now
        if (to_mcu) snd_hold = snd_rdata;
        else mcu_hold = mcu_rdata;
        wait_cen(to_mcu);
        @(negedge clk);                         // Last window edge has passed
        if (to_mcu) begin
            mcu_req = make_req(1'b0, 1'b1, 0, 0);
            mcu_chk = 1'b0;
        end else begin
            snd_req = make_req(1'b0, 1'b1, 0, 0);
            snd_chk = 1'b0;
        end
    endtask

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_chk_q <= 1'b0;
            bus_exp_q <= '0;
            ring_q    <= 1'b0;
        end else begin
            bus_chk_q <= bus_chk;               // Registered read data lags a cycle
            bus_exp_q <= bus_exp;
            ring_q    <= bus_req.cs && !bus_req.rnw && (bus_req.addr == '0);
        end
    end

    // Enable spacing reference
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seen_snd <= 1'b0;
            snd_gap  <= 0;
        end else if (snd_cen) begin
            seen_snd <= 1'b1;
            snd_gap  <= 1;
        end else begin
            snd_gap <= snd_gap + 1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) abort_run("Run exceeded its cycle limit, DUT stuck");
    end

    a_cen_apart : assert property (@(posedge clk) disable iff (!arst_n)
        !(snd_cen && mcu_cen)) else abort_run("snd_cen and mcu_cen high in one cycle");
    a_snd_period : assert property (@(posedge clk) disable iff (!arst_n)
        seen_snd |-> (snd_cen == (snd_gap == cpu_period)))
        else report_fail("snd_cen period", $sampled(snd_gap) == cpu_period, $sampled(snd_cen));
    a_mcu_phase : assert property (@(posedge clk) disable iff (!arst_n)
        seen_snd |-> (mcu_cen == (snd_gap == cpu_period / 2)))
        else report_fail("mcu_cen phase", $sampled(snd_gap) == cpu_period / 2, $sampled(mcu_cen));
    a_bus_read : assert property (@(posedge clk) disable iff (!arst_n)
        bus_chk_q |-> (bus_rdata == bus_exp_q))
        else report_fail("bus read", $sampled(bus_exp_q), $sampled(bus_rdata));
    a_mcu_read : assert property (@(posedge clk) disable iff (!arst_n)
        (mcu_cen && mcu_chk) |-> (mcu_rdata == mcu_exp))
        else report_fail("mcu read", $sampled(mcu_exp), $sampled(mcu_rdata));
    a_mcu_other : assert property (@(posedge clk) disable iff (!arst_n)
        (mcu_cen && mcu_chk) |-> (snd_rdata == snd_hold))
        else report_fail("snd hold", $sampled(snd_hold), $sampled(snd_rdata));
    a_snd_read : assert property (@(posedge clk) disable iff (!arst_n)
        (snd_cen && snd_chk) |-> (snd_rdata == snd_exp))
        else report_fail("snd read", $sampled(snd_exp), $sampled(snd_rdata));
    a_snd_other : assert property (@(posedge clk) disable iff (!arst_n)
        (snd_cen && snd_chk) |-> (mcu_rdata == mcu_hold))
        else report_fail("mcu hold", $sampled(mcu_hold), $sampled(mcu_rdata));
    a_ring : assert property (@(posedge clk) disable iff (!arst_n)
        ring_q |-> mcu_irq) else report_fail("mcu bell ring", 1, $sampled(mcu_irq));
    a_mcu_irq : assert property (@(posedge clk) disable iff (!arst_n)
        mcu_irq_chk |-> (mcu_irq == mcu_irq_exp))
        else report_fail("mcu_irq level", $sampled(mcu_irq_exp), $sampled(mcu_irq));
    a_bus_irq : assert property (@(posedge clk) disable iff (!arst_n)
        bus_irq_chk |-> (bus_irq == bus_irq_exp))
        else report_fail("bus_irq level", $sampled(bus_irq_exp), $sampled(bus_irq));

    initial begin
        int a;
        int d;
        int wr_addrs[$];
        void'($urandom(33));
        bus_req = make_req(1'b0, 1'b1, 0, 0);
        mcu_req = make_req(1'b0, 1'b1, 0, 0);
        snd_req = make_req(1'b0, 1'b1, 0, 0);
        bus_chk = 1'b0;
        bus_exp = '0;
        mcu_chk = 1'b0;
        snd_chk = 1'b0;
        mcu_exp = '0;
        snd_exp = '0;
        mcu_hold = '0;
        snd_hold = '0;
        mcu_irq_chk = 1'b1;                     // Both bells low from reset on
        bus_irq_chk = 1'b1;
        mcu_irq_exp = 1'b0;
        bus_irq_exp = 1'b0;
        @(posedge arst_n);
        repeat (2) @(negedge clk);
        repeat (200) begin                      // Main bus, word 0 kept for the bells
            a = 1 + int'($urandom % 1023);
            d = int'($urandom % 256);
            bus_write(a, d);
            bus_read(a);
        end
        bus_idle();
        repeat (8) begin                        // Port 1 writes in the upper KB
            a = 'h400 + int'($urandom % 1024);
            slot_access(1'b0, 1'b0, a, int'($urandom % 256));
            wr_addrs.push_back(a);
            a = 'h400 + int'($urandom % 1024);
            slot_access(1'b1, 1'b0, a, int'($urandom % 256));
            wr_addrs.push_back(a);
        end
        foreach (wr_addrs[i]) bus_read(wr_addrs[i]);
        bus_idle();
        repeat (8) begin                        // Main bus fill, then both sides read it
            a = 'h400 + int'($urandom % 1024);
            bus_write(a, int'($urandom % 256));
            bus_idle();
            slot_access(1'b0, 1'b1, a, 0);
            slot_access(1'b1, 1'b1, a, 0);
        end
        bus_write(0, int'($urandom % 256));     // Ring the MCU
        bus_idle();
        mcu_irq_exp = 1'b1;
        repeat (3) @(negedge clk);
        slot_access(1'b0, 1'b1, 0, 0);          // Sound read of word 0, bell stays
        wait_cen(1'b1);
        mcu_irq_chk = 1'b0;                     // Clears inside the MCU window
        slot_access(1'b1, 1'b1, 0, 0);
        mcu_irq_exp = 1'b0;
        mcu_irq_chk = 1'b1;
        bus_irq_chk = 1'b0;
        slot_access(1'b0, 1'b0, 0, int'($urandom % 256));  // Sound rings the main bus
        bus_irq_exp = 1'b1;
        bus_irq_chk = 1'b1;
        repeat (3) @(negedge clk);
        bus_read(0);                            // Main bus acknowledge
        bus_idle();
        bus_irq_exp = 1'b0;
        repeat (4) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: src.f
logic/bus_pkg.sv
logic/slice_pkg.sv
logic/dual_ram.sv
logic/cen_gen.sv
logic/tri_ram.sv
logic/doorbell.sv
logic/shared_ram_top.sv
tb/tb_clock.sv
tb/shared_ram_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the shared RAM testbench with Verilator
set -e
cd "$(dirname "$0")"

# Timed binary build, concurrent assertions enabled
verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module shared_ram_tb \
    -f src.f \
    -o shared_ram_sim

# Non-zero exit when the testbench ends in $fatal
./obj_dir/shared_ram_sim
